// ==== gfx_pkg.sv ====
//******************
// shared widths, opcode and state enums,
// apb register offsets and the colour palette
//******************
package gfx_pkg;

    localparam int CIDXW = 2;       // colour index bits
    localparam int CHANW = 4;       // bits per colour channel
    localparam int CORDW = 10;      // signed coordinate bits
    localparam int RGBW  = 3*CHANW; // packed red, green, blue

    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,
        OP_DRAW_TRI = 2'd1,
        OP_CLEAR    = 2'd2
    } gfx_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_EDGE_INIT,
        ST_EDGE_STEP,
        ST_CLEAR,
        ST_DONE
    } raster_state_t;

    // apb byte offsets
    localparam logic [7:0] REG_V0     = 8'h00;  // x in [7:0], y in [15:8]
    localparam logic [7:0] REG_V1     = 8'h04;
    localparam logic [7:0] REG_V2     = 8'h08;
    localparam logic [7:0] REG_COLR   = 8'h0C;  // index in [1:0]
    localparam logic [7:0] REG_CMD    = 8'h10;
    localparam logic [7:0] REG_STATUS = 8'h14;  // busy in bit 0

    // black, orange, green, blue
    localparam logic [RGBW-1:0] PALETTE [2**CIDXW] = '{
        12'h000, 12'hF80, 12'h0C0, 12'h05F
    };

endpackage

// ==== display_timings.sv ====
//******************
// display timing generator, counters,
// sync pulses, data enable and strobes
//******************
`timescale 1ns/1ps

module display_timings import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 90,
    parameter int FB_SCALE  = 4,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33
) (
    input  logic                    clk_pix,
    input  logic                    reset,
    output logic signed [CORDW-1:0] sx,
    output logic signed [CORDW-1:0] sy,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output logic                    frame,
    output logic                    line
);

    // blanking runs at negative positions, active area starts at 0
    localparam int H_STA  = -(H_FP + H_SYNC + H_BP);
    localparam int HS_STA = H_STA + H_FP;
    localparam int HS_END = HS_STA + H_SYNC;
    localparam int H_END  = FB_WIDTH*FB_SCALE - 1;
    localparam int V_STA  = -(V_FP + V_SYNC + V_BP);
    localparam int VS_STA = V_STA + V_FP;
    localparam int VS_END = VS_STA + V_SYNC;
    localparam int V_END  = FB_HEIGHT*FB_SCALE - 1;
    localparam int CW     = CORDW + 2;  // headroom for the full scan range

    logic signed [CW-1:0] h_cnt;
    logic signed [CW-1:0] v_cnt;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            h_cnt <= CW'(H_STA);
            v_cnt <= CW'(V_STA);
        end else if (h_cnt == H_END) begin
            h_cnt <= CW'(H_STA);
            v_cnt <= (v_cnt == V_END) ? CW'(V_STA) : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign sx    = h_cnt[CORDW-1:0];
    assign sy    = v_cnt[CORDW-1:0];
    assign hsync = (h_cnt >= HS_STA) && (h_cnt < HS_END);  // active high
    assign vsync = (v_cnt >= VS_STA) && (v_cnt < VS_END);
    assign de    = (h_cnt >= 0) && (v_cnt >= 0);
    assign line  = (h_cnt == H_STA);
    assign frame = (h_cnt == H_STA) && (v_cnt == V_STA);

    a_scan_bounds: assert property (@(posedge clk_pix) disable iff (reset)
        (h_cnt <= H_END) && (v_cnt <= V_END));

endmodule

// ==== draw_cmd_decode.sv ====
//******************
// apb register block, decodes command
// writes into raster job starts
//******************
`timescale 1ns/1ps

module draw_cmd_decode import gfx_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    input  logic                    busy,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    start,
    output gfx_op_t                 op,
    output logic signed [CORDW-1:0] x0,
    output logic signed [CORDW-1:0] y0,
    output logic signed [CORDW-1:0] x1,
    output logic signed [CORDW-1:0] y1,
    output logic signed [CORDW-1:0] x2,
    output logic signed [CORDW-1:0] y2,
    output logic [CIDXW-1:0]        colr
);

    logic [15:0]      v0_q, v1_q, v2_q;  // {y, x} bytes
    logic [CIDXW-1:0] colr_q;
    logic             wr, mapped, cmd_wr, engine_busy, cmd_ok;
    gfx_op_t          cmd_op;

    assign wr          = psel && penable && pwrite;  // access phase
    assign mapped      = paddr inside {REG_V0, REG_V1, REG_V2, REG_COLR, REG_CMD, REG_STATUS};
    assign cmd_wr      = wr && (paddr == REG_CMD);
    assign engine_busy = busy || start;  // start cycle counts as busy
    assign cmd_ok      = cmd_wr && !engine_busy;
    assign pready      = 1'b1;            // no wait states
    assign pslverr     = wr && (!mapped || (cmd_wr && engine_busy));

    always_comb begin
        case (pwdata[1:0])
            2'd1:    cmd_op = OP_DRAW_TRI;
            2'd2:    cmd_op = OP_CLEAR;
            default: cmd_op = OP_NOP;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (wr && !pslverr) begin
            case (paddr)
                REG_V0:   v0_q   <= pwdata[15:0];
                REG_V1:   v1_q   <= pwdata[15:0];
                REG_V2:   v2_q   <= pwdata[15:0];
                REG_COLR: colr_q <= pwdata[CIDXW-1:0];
                default:  ;  // cmd and status handled elsewhere
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            start <= 1'b0;
            op    <= OP_NOP;
        end else begin
            start <= cmd_ok && (cmd_op != OP_NOP);
            if (cmd_ok) op <= cmd_op;
        end
    end

    // job fields held for the whole job
    always_ff @(posedge clk_pix) begin
        if (cmd_ok) begin
            x0   <= CORDW'(v0_q[7:0]);
            y0   <= CORDW'(v0_q[15:8]);
            x1   <= CORDW'(v1_q[7:0]);
            y1   <= CORDW'(v1_q[15:8]);
            x2   <= CORDW'(v2_q[7:0]);
            y2   <= CORDW'(v2_q[15:8]);
            colr <= colr_q;
        end
    end

    always_comb begin
        case (paddr)
            REG_V0:     prdata = {16'h0, v0_q};
            REG_V1:     prdata = {16'h0, v1_q};
            REG_V2:     prdata = {16'h0, v2_q};
            REG_COLR:   prdata = 32'(colr_q);
            REG_CMD:    prdata = 32'(op);
            REG_STATUS: prdata = 32'(busy);
            default:    prdata = 32'h0;
        endcase
    end

    // a new job must never launch over a running one
    a_start_idle: assert property (@(posedge clk_pix) disable iff (reset)
        !(start && busy));
    a_penable_sel: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(penable) |-> psel);

endmodule

// ==== raster_engine.sv ====
//******************
// triangle outline line drawer and
// framebuffer clear sweeper
//******************
`timescale 1ns/1ps

module raster_engine import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 90
) (
    input  logic                    clk_pix,
    input  logic                    reset,
    input  logic                    start,
    input  gfx_op_t                 op,
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    input  logic signed [CORDW-1:0] x2,
    input  logic signed [CORDW-1:0] y2,
    input  logic [CIDXW-1:0]        colr,
    output logic                    busy,
    output logic                    we,
    output logic signed [CORDW-1:0] wx,
    output logic signed [CORDW-1:0] wy,
    output logic [CIDXW-1:0]        wcidx
);

    raster_state_t            state;
    logic [1:0]               edge_idx;  // 0: v0-v1, 1: v1-v2, 2: v2-v0
    logic signed [CORDW-1:0]  x, y, xe, ye;
    logic signed [CORDW-1:0]  ax, ay, bx, by;
    logic signed [CORDW:0]    ddx, ddy, adx, ady, dx, dy;
    logic signed [CORDW+1:0]  err, err_nx;
    logic signed [CORDW+2:0]  e2;
    logic                     x_neg, y_neg, step_x, step_y;

    always_comb begin
        case (edge_idx)
            2'd0:    begin ax = x0; ay = y0; bx = x1; by = y1; end
            2'd1:    begin ax = x1; ay = y1; bx = x2; by = y2; end
            default: begin ax = x2; ay = y2; bx = x0; by = y0; end
        endcase
    end

    assign ddx = bx - ax;
    assign ddy = by - ay;
    assign adx = (ddx < 0) ? -ddx : ddx;
    assign ady = (ddy < 0) ? -ddy : ddy;

    // error term step, dy is held negative
    assign e2     = {err, 1'b0};
    assign step_x = (e2 >= dy);
    assign step_y = (e2 <= dx);

    always_comb begin
        err_nx = err;
        if (step_x) err_nx = err_nx + dy;
        if (step_y) err_nx = err_nx + dx;
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state    <= ST_IDLE;
            edge_idx <= 2'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    edge_idx <= 2'd0;
                    x        <= '0;
                    y        <= '0;
                    if (start && op == OP_DRAW_TRI) state <= ST_EDGE_INIT;
                    if (start && op == OP_CLEAR)    state <= ST_CLEAR;
                end
                ST_EDGE_INIT: begin  // load one edge
                    x     <= ax;
                    y     <= ay;
                    xe    <= bx;
                    ye    <= by;
                    x_neg <= (ddx < 0);
                    y_neg <= (ddy < 0);
                    dx    <= adx;
                    dy    <= -ady;
                    err   <= adx - ady;
                    state <= ST_EDGE_STEP;
                end
                ST_EDGE_STEP: begin  // one pixel per cycle
                    if (x == xe && y == ye) begin
                        edge_idx <= edge_idx + 1'b1;
                        state    <= (edge_idx == 2'd2) ? ST_DONE : ST_EDGE_INIT;
                    end else begin
                        err <= err_nx;
                        if (step_x) x <= x_neg ? x - 1'b1 : x + 1'b1;
                        if (step_y) y <= y_neg ? y - 1'b1 : y + 1'b1;
                    end
                end
                ST_CLEAR: begin  // raster order sweep
                    if (x == FB_WIDTH-1) begin
                        x <= '0;
                        y <= y + 1'b1;
                        if (y == FB_HEIGHT-1) state <= ST_DONE;
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                default: state <= ST_IDLE;  // done
            endcase
        end
    end

    assign busy  = (state != ST_IDLE);
    assign we    = (state == ST_EDGE_STEP) || (state == ST_CLEAR);
    assign wx    = x;
    assign wy    = y;
    assign wcidx = colr;

    a_draw_bbox: assert property (@(posedge clk_pix) disable iff (reset)
        (we && state == ST_EDGE_STEP) |->
            (wx >= x0 || wx >= x1 || wx >= x2) && (wx <= x0 || wx <= x1 || wx <= x2) &&
            (wy >= y0 || wy >= y1 || wy >= y2) && (wy <= y0 || wy <= y1 || wy <= y2));
    a_we_busy: assert property (@(posedge clk_pix) disable iff (reset) we |-> busy);

endmodule

// ==== framebuffer.sv ====
//******************
// colour index framebuffer with scaled
// scan readout and palette lookup
//******************
`timescale 1ns/1ps

module framebuffer import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 90,
    parameter int FB_SCALE  = 4
) (
    input  logic                    clk_pix,
    input  logic                    reset,
    input  logic                    we,
    input  logic signed [CORDW-1:0] wx,
    input  logic signed [CORDW-1:0] wy,
    input  logic [CIDXW-1:0]        wcidx,
    input  logic signed [CORDW-1:0] sx,
    input  logic signed [CORDW-1:0] sy,
    input  logic                    de,
    input  logic                    hsync,
    input  logic                    vsync,
    output logic                    de_out,
    output logic                    hsync_out,
    output logic                    vsync_out,
    output logic [CHANW-1:0]        red,
    output logic [CHANW-1:0]        green,
    output logic [CHANW-1:0]        blue
);

    localparam int FB_PIX = FB_WIDTH*FB_HEIGHT;
    localparam int RW     = $clog2(FB_PIX+1);
    localparam int XW     = $clog2(FB_WIDTH+1);
    localparam int SW     = $clog2(FB_SCALE+1);

    logic [CIDXW-1:0] mem [FB_PIX];
    logic [CIDXW-1:0] cidx_q;
    logic [RW-1:0]    wr_addr, rd_addr, row_base, rbase;
    logic [XW-1:0]    col, cx;
    logic [SW-1:0]    col_sub, csub, row_sub, rsub;
    logic             in_range, col_start, row_start, line_end;

    // write side, off-screen writes dropped
    assign in_range = (wx >= 0) && (wx < FB_WIDTH) && (wy >= 0) && (wy < FB_HEIGHT);
    assign wr_addr  = RW'(int'(wy)*FB_WIDTH + int'(wx));

    always_ff @(posedge clk_pix) begin
        if (we && in_range) mem[wr_addr] <= wcidx;
    end

    // scan position divided by the scale with counters
    assign col_start = (sx == 0);
    assign row_start = col_start && (sy == 0);
    assign cx        = col_start ? '0 : col;
    assign csub      = col_start ? '0 : col_sub;
    assign rbase     = row_start ? '0 : row_base;
    assign rsub      = row_start ? '0 : row_sub;
    assign line_end  = (cx == FB_WIDTH-1) && (csub == FB_SCALE-1);
    assign rd_addr   = rbase + RW'(cx);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            col      <= '0;
            col_sub  <= '0;
            row_base <= '0;
            row_sub  <= '0;
        end else if (de) begin
            col      <= (csub == FB_SCALE-1) ? cx + 1'b1 : cx;
            col_sub  <= (csub == FB_SCALE-1) ? '0 : csub + 1'b1;
            row_base <= rbase;
            row_sub  <= rsub;
            if (line_end && rsub == FB_SCALE-1) begin  // next source row
                row_base <= rbase + RW'(FB_WIDTH);
                row_sub  <= '0;
            end else if (line_end) begin
                row_sub  <= rsub + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (de) cidx_q <= mem[rd_addr];
    end

    // sync and enable delayed to match the read
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            de_out    <= 1'b0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            de_out    <= de;
            hsync_out <= hsync;
            vsync_out <= vsync;
        end
    end

    assign {red, green, blue} = de_out ? PALETTE[cidx_q] : '0;  // black in blanking

endmodule

// ==== gfx_top.sv ====
//******************
// graphics top level, apb decode,
// raster engine, framebuffer and timing
//******************
`timescale 1ns/1ps

module gfx_top import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 90,
    parameter int FB_SCALE  = 4,
    parameter int H_FP      = 16,   // 640x480-like porches
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33
) (
    input  logic             clk_pix,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [7:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output logic [CHANW-1:0] red,
    output logic [CHANW-1:0] green,
    output logic [CHANW-1:0] blue
);

    logic signed [CORDW-1:0] sx, sy, x0, y0, x1, y1, x2, y2, wx, wy;
    logic                    scan_hsync, scan_vsync, scan_de;
    logic                    start, busy, we;
    logic [CIDXW-1:0]        colr, wcidx;
    gfx_op_t                 op;

    display_timings #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) i_timings (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .hsync(scan_hsync),
        .vsync(scan_vsync),
        .de(scan_de),
        .frame(),   // strobes not needed here
        .line()
    );

    draw_cmd_decode i_decode (
        .clk_pix, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .busy,
        .prdata, .pready, .pslverr,
        .start, .op,
        .x0, .y0, .x1, .y1, .x2, .y2,
        .colr
    );

    raster_engine #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) i_raster (
        .clk_pix, .reset,
        .start, .op,
        .x0, .y0, .x1, .y1, .x2, .y2,
        .colr,
        .busy, .we, .wx, .wy, .wcidx
    );

    framebuffer #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) i_fb (
        .clk_pix, .reset,
        .we, .wx, .wy, .wcidx,
        .sx, .sy,
        .de(scan_de),
        .hsync(scan_hsync),
        .vsync(scan_vsync),
        .de_out(de),
        .hsync_out(hsync),
        .vsync_out(vsync),
        .red, .green, .blue
    );

endmodule

// ==== tb_gfx.sv ====
//******************
// testbench for gfx_top, apb driver,
// video monitor, checks and timeout
//******************
`timescale 1ns/1ps

module tb_gfx import gfx_pkg::*; ();

    localparam int W = 16, H = 12, S = 1;
    localparam int H_FP = 2, H_SYNC = 3, H_BP = 3, V_FP = 1, V_SYNC = 2, V_BP = 2;
    localparam int LINE_TOTAL = W*S + H_FP + H_SYNC + H_BP;
    localparam int FRAME_CYC  = LINE_TOTAL * (H*S + V_FP + V_SYNC + V_BP);
    localparam int LIMIT      = 2 * (8*W*H + 5*3*FRAME_CYC);  // jobs plus frames per test

    logic clk_pix, reset, psel, penable, pwrite, pready, pslverr, hsync, vsync, de;
    logic [7:0]       paddr;
    logic [31:0]      pwdata, prdata;
    logic [CHANW-1:0] red, green, blue;

    int seed = 85525;
    int errors = 0, test_err0 = 0, tests_run = 0, tests_failed = 0, cycles = 0;
    bit mon_on = 0, frame_on = 0, vid_chk = 0, rd_chk = 0, exp_slverr = 0;
    int chk_mode = 0;  // 0 off, 1 whole frame, 2 outline targets
    logic [31:0]     exp_rdata = '0;
    logic [RGBW-1:0] exp_rgb = '0;
    int tx [3], ty [3];

    // monitor state, refreshed on the falling edge
    logic obs_de = 0, obs_vs = 0, obs_hs = 0, obs_tgt = 0;
    logic obs_de_fall = 0, obs_hs_rise = 0, obs_vs_rise = 0;
    logic [RGBW-1:0] obs_rgb = '0;
    int obs_col = 0, obs_row = 0, de_run = 0, line_cnt = 0, frame_lines = 0;
    int hs_gap = 0, last_gap = 0, hs_seen = 0, frames_seen = 0;

    gfx_top #(
        .FB_WIDTH(W), .FB_HEIGHT(H), .FB_SCALE(S),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) i_dut (
        .clk_pix, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .hsync, .vsync, .de,
        .red, .green, .blue
    );

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", LIMIT);
        $display("** FAIL **");
        $finish;
    end

    function automatic int pick(input int n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    // vertices of the drawn triangle plus the v0 to v1 row
    function automatic bit is_target(input int c, input int r);
        int fc, fr, lo, hi;
        bit hit;
        fc  = c / S;
        fr  = r / S;
        lo  = (tx[0] < tx[1]) ? tx[0] : tx[1];
        hi  = (tx[0] < tx[1]) ? tx[1] : tx[0];
        hit = (fr == ty[0]) && (fc >= lo) && (fc <= hi);
        for (int i = 0; i < 3; i++) begin
            if (fc == tx[i] && fr == ty[i]) hit = 1'b1;
        end
        is_target = hit;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("ERR %0t ns %s expected %h got %h", $time, sig, exp, got);
    endtask

    always @(negedge clk_pix) begin : monitor
        int c, r;
        c = (de && !obs_de) ? 0 : obs_col + 1;
        r = (vsync && !obs_vs) ? -1 : obs_row;
        if (de && !obs_de) r = r + 1;          // new active line
        obs_de      <= de;
        obs_vs      <= vsync;
        obs_hs      <= hsync;
        obs_rgb     <= {red, green, blue};
        obs_col     <= c;
        obs_row     <= r;
        obs_tgt     <= de && is_target(c, r);
        obs_de_fall <= obs_de && !de;
        obs_hs_rise <= hsync && !obs_hs;
        obs_vs_rise <= vsync && !obs_vs;
        if (de) de_run <= obs_de ? de_run + 1 : 1;
        if (hsync && !obs_hs) begin
            last_gap <= hs_gap;
            hs_gap   <= 1;
            hs_seen  <= hs_seen + 1;
        end else begin
            hs_gap <= hs_gap + 1;
        end
        if (vsync && !obs_vs) begin
            frame_lines <= line_cnt;
            line_cnt    <= 0;
            frames_seen <= frames_seen + 1;
        end else if (de && !obs_de) begin
            line_cnt <= line_cnt + 1;
        end
    end

    // apb responses, stable on the falling edge
    a_slverr: assert property (@(negedge clk_pix) (psel && penable) |-> pslverr == exp_slverr)
        else report_mismatch("pslverr", 32'(exp_slverr), 32'(pslverr));
    a_rdata: assert property (@(negedge clk_pix)
        (psel && penable && !pwrite && rd_chk) |-> prdata == exp_rdata)
        else report_mismatch("prdata", exp_rdata, prdata);
    a_ready: assert property (@(negedge clk_pix) (psel && penable) |-> pready == 1'b1)
        else report_mismatch("pready", 32'h1, 32'(pready));

    // video, from the monitor registers
    a_fill: assert property (@(posedge clk_pix)
        (frame_on && chk_mode == 1 && obs_de) |-> obs_rgb == exp_rgb)
        else report_mismatch("rgb", 32'(exp_rgb), 32'(obs_rgb));
    a_blank: assert property (@(posedge clk_pix) (mon_on && !obs_de) |-> obs_rgb == '0)
        else report_mismatch("rgb in blanking", 32'h0, 32'(obs_rgb));
    a_outline: assert property (@(posedge clk_pix)
        (frame_on && chk_mode == 2 && obs_tgt) |-> obs_rgb == exp_rgb)
        else report_mismatch("rgb at outline", 32'(exp_rgb), 32'(obs_rgb));
    a_de_len: assert property (@(posedge clk_pix) (vid_chk && obs_de_fall) |-> de_run == W*S)
        else report_mismatch("de cycles per line", 32'(W*S), 32'(de_run));
    a_lines: assert property (@(posedge clk_pix)
        (vid_chk && obs_vs_rise && frames_seen >= 2) |-> frame_lines == H*S)
        else report_mismatch("lines per frame", 32'(H*S), 32'(frame_lines));
    a_hs_gap: assert property (@(posedge clk_pix)
        (vid_chk && obs_hs_rise && hs_seen >= 2) |-> last_gap == LINE_TOTAL)
        else report_mismatch("hsync period", 32'(LINE_TOTAL), 32'(last_gap));

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input bit err);
        @(posedge clk_pix);
        exp_slverr = err;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_pix);
        penable <= 1'b1;  // access phase
        @(posedge clk_pix);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input bit chk, input logic [31:0] exp,
                            output logic [31:0] data);
        @(posedge clk_pix);
        exp_slverr = 1'b0;
        rd_chk     = chk;
        exp_rdata  = exp;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_pix);
        penable <= 1'b1;
        @(negedge clk_pix);
        data = prdata;
        @(posedge clk_pix);
        psel    <= 1'b0;
        penable <= 1'b0;
        rd_chk  = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        apb_read(REG_STATUS, 1'b1, 32'd1, st);  // busy already visible
        while (st[0]) apb_read(REG_STATUS, 1'b0, 32'd0, st);
    endtask

    task automatic run_job(input gfx_op_t op, input int c);
        apb_write(REG_COLR, 32'(c), 1'b0);
        apb_write(REG_CMD, 32'(op), 1'b0);
        wait_idle();
    endtask

    task automatic wait_vsync_rise();
        @(negedge clk_pix);
        while (!(vsync && !obs_vs)) @(negedge clk_pix);
    endtask

    task automatic watch_frame();
        wait_vsync_rise();
        frame_on = 1'b1;
        wait_vsync_rise();
        frame_on = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_err0);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_err0 = errors;
    endtask

    initial begin : main
        logic [31:0] rd;
        logic [7:0]  vx, vy;
        int          c;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        reset   = 1'b1;
        repeat (2) @(posedge clk_pix);
        reset <= 1'b0;
        @(negedge clk_pix);
        mon_on = 1'b1;

        for (int i = 0; i < 3; i++) begin
            vx = 8'(pick(W));
            vy = 8'(pick(H));
            apb_write(8'(REG_V0 + 4*i), {16'h0, vy, vx}, 1'b0);
            apb_read(8'(REG_V0 + 4*i), 1'b1, {16'h0, vy, vx}, rd);
        end
        c = pick(4);
        apb_write(REG_COLR, 32'(c), 1'b0);
        apb_read(REG_COLR, 1'b1, 32'(c), rd);
        apb_write(8'h18, 32'h1, 1'b1);      // unmapped offset
        apb_read(REG_STATUS, 1'b1, 32'd0, rd);
        end_test("apb registers");

        c = pick(4);
        run_job(OP_CLEAR, c);
        exp_rgb  = PALETTE[c];
        chk_mode = 1;
        watch_frame();
        chk_mode = 0;
        end_test("clear");

        run_job(OP_CLEAR, 0);
        for (int i = 0; i < 3; i++) begin
            tx[i] = pick(W);
            ty[i] = pick(H);
        end
        ty[1] = ty[0];  // first edge runs along the row of v0
        for (int i = 0; i < 3; i++) begin
            apb_write(8'(REG_V0 + 4*i), {16'h0, 8'(ty[i]), 8'(tx[i])}, 1'b0);
        end
        c = 1 + pick(3);
        run_job(OP_DRAW_TRI, c);
        exp_rgb  = PALETTE[c];
        chk_mode = 2;
        watch_frame();
        chk_mode = 0;
        end_test("triangle outline");

        c = pick(4);
        apb_write(REG_COLR, 32'(c), 1'b0);
        apb_write(REG_CMD, 32'(OP_CLEAR), 1'b0);
        apb_write(REG_COLR, 32'((c + 1) % 4), 1'b0);
        apb_write(REG_CMD, 32'(OP_CLEAR), 1'b1);  // engine still sweeping
        wait_idle();
        exp_rgb  = PALETTE[c];
        chk_mode = 1;
        watch_frame();
        chk_mode = 0;
        end_test("busy refusal");

        vid_chk = 1'b1;
        repeat (3) wait_vsync_rise();
        vid_chk = 1'b0;
        end_test("video timing");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
gfx_pkg.sv
display_timings.sv
draw_cmd_decode.sv
raster_engine.sv
framebuffer.sv
gfx_top.sv
tb_gfx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gfx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx -f sources.f -o tb_gfx

out=$(./obj_dir/tb_gfx)
echo "$out"

echo "$out" | grep -qx '\*\* PASS \*\*'
